/* hdl/core_pkg.sv */
/*
 * Core constants for the four stage RV32 integer pipeline
 * Major opcodes, funct3 codes and ALU operation encoding
 * IF/ID, ID/EX and EX/WB pipeline payload structs
 */
package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Data and address width, one word
  localparam int XLEN       = 32;
  // Register index width
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  //////////////////////////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////////////////////////

  // Major opcodes kept by the decoder, all others decode as NOP
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // funct3 for STORE, word only
  localparam logic [2:0] F3_SW      = 3'b010;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B  // LUI result is operand B
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Pipeline payloads
  //////////////////////////////////////////////////////////////////////

  // Fetched word with its address, 65 bits
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_pipe_t;

  // Decoded operation with forwarded operands
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       store_data;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  is_store;
  } id_ex_pipe_t;

  // Register write, also the forwarding source
  typedef struct packed {
    logic                  valid;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;
  } ex_wb_pipe_t;

endpackage

/* hdl/obi_pkg.sv */
/*
 * OBI payload types
 * Instruction and data request structs, shared response struct
 */
package obi_pkg;

  // Byte enables per word
  localparam int BE_W = 4;

  // Instruction fetch request, address only
  typedef struct packed {
    logic [core_pkg::XLEN-1:0] addr;
  } obi_inst_req_t;

  // Data request, write only
  typedef struct packed {
    logic [core_pkg::XLEN-1:0] addr;
    logic [core_pkg::XLEN-1:0] wdata;
    // All ones for SW
    logic [BE_W-1:0]           be;
  } obi_data_req_t;

  // Response payload
  // Data port has no read path and does not look at it
  typedef struct packed {
    logic [core_pkg::XLEN-1:0] rdata;
    logic                      err;
  } obi_resp_t;

endpackage

/* hdl/obi_port.sv */
/*
 * OBI master port, payload type set per instance
 * Holds an ungranted request, tracks one outstanding transfer
 */
module obi_port #(
  parameter type REQ_T = obi_pkg::obi_inst_req_t
) (
  input  logic clk_i,
  input  logic rst_n_i,
  // Upstream side
  input  logic valid_i,
  input  REQ_T payload_i,
  output logic ready_o,
  output logic done_o,
  // Bus side
  output logic req_o,
  output REQ_T payload_o,
  input  logic gnt_i,
  input  logic rvalid_i
);

  logic pending_q;
  logic outstanding_q;
  logic issue_ok;
  REQ_T payload_q;

  // Issue only once the previous response is in
  assign issue_ok  = !outstanding_q || rvalid_i;
  assign req_o     = pending_q || (valid_i && issue_ok);
  // Frozen copy after the first ungranted cycle
  assign payload_o = pending_q ? payload_q : payload_i;
  // Upstream item taken on grant
  assign ready_o   = req_o && gnt_i;
  assign done_o    = rvalid_i && outstanding_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q     <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      pending_q <= req_o && !gnt_i;
      // Grant wins over a same-cycle response of the older transfer
      if (req_o && gnt_i) begin
        outstanding_q <= 1'b1;
      end else if (rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Payload capture
  always_ff @(posedge clk_i) begin
    if (!pending_q) begin
      payload_q <= payload_i;
    end
  end

  // Address phase holds until granted
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_o && !gnt_i |=> req_o && $stable(payload_o));

  // Bus responds only to a granted transfer
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i |-> outstanding_q);

endmodule

/* hdl/if_stage.sv */
/*
 * Fetch stage
 * Program counter, instruction OBI requests, IF/ID register
 */
module if_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  input  logic                      fetch_enable_i,
  // Pipeline handshake
  input  logic                      id_ready_i,
  output core_pkg::if_id_pipe_t     if_id_pipe_o,
  // Instruction OBI
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i
);
  import core_pkg::*;
  import obi_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] fetch_addr_q;
  logic            fetch_valid;
  logic            fetch_gnt;
  logic            fetch_done;
  obi_inst_req_t   fetch_req;
  obi_inst_req_t   fetch_bus;
  if_id_pipe_t     if_id_q;

  // IF/ID must be empty when the word returns
  // Slot free or draining now, and no word landing this cycle
  assign fetch_valid = fetch_enable_i && (!if_id_q.valid || id_ready_i) && !fetch_done;
  assign fetch_req.addr = pc_q;

  obi_port #(
    .REQ_T     (obi_inst_req_t)
  ) instr_port_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (fetch_valid),
    .payload_i (fetch_req),
    .ready_o   (fetch_gnt),
    .done_o    (fetch_done),
    .req_o     (instr_req_o),
    .payload_o (fetch_bus),
    .gnt_i     (instr_gnt_i),
    .rvalid_i  (instr_rvalid_i)
  );

  assign instr_addr_o = fetch_bus.addr;

  // PC steps on grant
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_q <= boot_addr_i;
    end else if (fetch_gnt) begin
      pc_q <= pc_q + XLEN'(4);
    end
  end

  // Address of the transfer in flight
  always_ff @(posedge clk_i) begin
    if (fetch_gnt) begin
      fetch_addr_q <= pc_q;
    end
  end

  // IF/ID register
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      if_id_q <= '0;
    end else if (fetch_done) begin
      if_id_q.valid <= 1'b1;
      if_id_q.pc    <= fetch_addr_q;
      if_id_q.instr <= instr_rdata_i;
    end else if (id_ready_i) begin
      // Taken by ID, or already empty
      if_id_q.valid <= 1'b0;
    end
  end

  assign if_id_pipe_o = if_id_q;

endmodule

/* hdl/id_stage.sv */
/*
 * Decode stage
 * Decoder for OP, OP-IMM, LUI and SW, operand forwarding
 * ID/EX pipeline register
 */
module id_stage (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  core_pkg::if_id_pipe_t           if_id_pipe_i,
  // Pipeline handshake
  input  logic                            ex_ready_i,
  output logic                            id_ready_o,
  output core_pkg::id_ex_pipe_t           id_ex_pipe_o,
  // Register file read
  output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_raddr_b_o,
  input  logic [core_pkg::XLEN-1:0]       rf_rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]       rf_rdata_b_i,
  // Forwarding taps
  input  core_pkg::ex_wb_pipe_t           ex_result_i,
  input  core_pkg::ex_wb_pipe_t           wb_pipe_i
);
  import core_pkg::*;

  logic [XLEN-1:0]       instr;
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;
  logic [REG_ADDR_W-1:0] rd;
  logic [XLEN-1:0]       imm_i;
  logic [XLEN-1:0]       imm_s;
  logic [XLEN-1:0]       imm_u;
  logic [XLEN-1:0]       rs1_val;
  logic [XLEN-1:0]       rs2_val;
  id_ex_pipe_t           id_ex_next;
  id_ex_pipe_t           id_ex_q;

  //////////////////////////////////////////////////////////////////////
  // Field extraction
  //////////////////////////////////////////////////////////////////////

  assign instr  = if_id_pipe_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Sign extended I and S forms, U form in upper bits
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////

  // Youngest producer wins: EX, then WB, then the register file
  function automatic logic [XLEN-1:0] fwd_operand(
    input logic [REG_ADDR_W-1:0] raddr,
    input logic [XLEN-1:0]       rf_val,
    input ex_wb_pipe_t           ex_res,
    input ex_wb_pipe_t           wb_res
  );
    logic [XLEN-1:0] val;
    val = rf_val;
    if (raddr != '0 && wb_res.valid && wb_res.rf_we && wb_res.rf_waddr == raddr) begin
      val = wb_res.rf_wdata;
    end
    if (raddr != '0 && ex_res.valid && ex_res.rf_we && ex_res.rf_waddr == raddr) begin
      val = ex_res.rf_wdata;
    end
    return val;
  endfunction

  assign rs1_val = fwd_operand(rs1, rf_rdata_a_i, ex_result_i, wb_pipe_i);
  assign rs2_val = fwd_operand(rs2, rf_rdata_b_i, ex_result_i, wb_pipe_i);

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // NOP unless a kept opcode matches
    id_ex_next.valid      = if_id_pipe_i.valid;
    id_ex_next.alu_op     = ALU_ADD;
    id_ex_next.operand_a  = rs1_val;
    id_ex_next.operand_b  = rs2_val;
    id_ex_next.store_data = rs2_val;
    id_ex_next.rf_we      = 1'b0;
    id_ex_next.rf_waddr   = rd;
    id_ex_next.is_store   = 1'b0;
    case (opcode)
      OPC_OP, OPC_OP_IMM: begin
        id_ex_next.rf_we = 1'b1;
        if (opcode == OPC_OP_IMM) begin
          id_ex_next.operand_b = imm_i;
        end
        case (funct3)
          // Bit 30 selects SUB, register form only
          F3_ADD_SUB: id_ex_next.alu_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
          F3_XOR:     id_ex_next.alu_op = ALU_XOR;
          F3_OR:      id_ex_next.alu_op = ALU_OR;
          F3_AND:     id_ex_next.alu_op = ALU_AND;
          default:    id_ex_next.rf_we  = 1'b0;
        endcase
      end
      OPC_LUI: begin
        id_ex_next.alu_op    = ALU_PASS_B;
        id_ex_next.operand_b = imm_u;
        id_ex_next.rf_we     = 1'b1;
      end
      OPC_STORE: begin
        // Address is rs1 plus S immediate
        if (funct3 == F3_SW) begin
          id_ex_next.operand_b = imm_s;
          id_ex_next.is_store  = 1'b1;
        end
      end
      default: ;
    endcase
    // Writes to x0 dropped here
    if (rd == '0) begin
      id_ex_next.rf_we = 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  // Loads when EX moves on or holds a bubble
  assign id_ready_o = ex_ready_i || !id_ex_q.valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_ex_q <= '0;
    end else if (id_ready_o) begin
      id_ex_q <= id_ex_next;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

  // No write enable for x0 ever reaches EX
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    id_ex_q.valid |-> !(id_ex_q.rf_we && id_ex_q.rf_waddr == '0));

endmodule

/* hdl/ex_stage.sv */
/*
 * Execute stage
 * ALU, SW issue on the data OBI port, EX/WB register
 */
module ex_stage (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  core_pkg::id_ex_pipe_t     id_ex_pipe_i,
  output logic                      ex_ready_o,
  // Combinational result for forwarding
  output core_pkg::ex_wb_pipe_t     ex_result_o,
  output core_pkg::ex_wb_pipe_t     ex_wb_pipe_o,
  // Data OBI, write only
  output logic                      data_req_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  output logic [obi_pkg::BE_W-1:0]  data_be_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i
);
  import core_pkg::*;
  import obi_pkg::*;

  logic [XLEN-1:0] alu_result;
  logic            store_valid;
  logic            store_gnt;
  obi_data_req_t   store_req;
  obi_data_req_t   store_bus;
  ex_wb_pipe_t     ex_wb_q;

  // ALU
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_ADD:    alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      ALU_SUB:    alu_result = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      ALU_AND:    alu_result = id_ex_pipe_i.operand_a & id_ex_pipe_i.operand_b;
      ALU_OR:     alu_result = id_ex_pipe_i.operand_a | id_ex_pipe_i.operand_b;
      ALU_XOR:    alu_result = id_ex_pipe_i.operand_a ^ id_ex_pipe_i.operand_b;
      ALU_PASS_B: alu_result = id_ex_pipe_i.operand_b;
      default:    alu_result = '0;
    endcase
  end

  // Store request, address from the ALU adder
  assign store_valid     = id_ex_pipe_i.valid && id_ex_pipe_i.is_store;
  assign store_req.addr  = alu_result;
  assign store_req.wdata = id_ex_pipe_i.store_data;
  assign store_req.be    = '1;

  obi_port #(
    .REQ_T     (obi_data_req_t)
  ) data_port_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (store_valid),
    .payload_i (store_req),
    .ready_o   (store_gnt),
    .done_o    (),
    .req_o     (data_req_o),
    .payload_o (store_bus),
    .gnt_i     (data_gnt_i),
    .rvalid_i  (data_rvalid_i)
  );

  assign data_addr_o  = store_bus.addr;
  assign data_wdata_o = store_bus.wdata;
  assign data_be_o    = store_bus.be;

  // Store stays in EX until granted
  assign ex_ready_o = !store_valid || store_gnt;

  // Stores carry no register write
  assign ex_result_o.valid    = id_ex_pipe_i.valid && !id_ex_pipe_i.is_store;
  assign ex_result_o.rf_we    = id_ex_pipe_i.rf_we;
  assign ex_result_o.rf_waddr = id_ex_pipe_i.rf_waddr;
  assign ex_result_o.rf_wdata = alu_result;

  // EX/WB register, WB never stalls
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_wb_q <= '0;
    end else begin
      ex_wb_q <= ex_result_o;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

/* hdl/register_file.sv */
/*
 * Integer register file
 * Two read ports, one write port, x0 reads as zero
 */
module register_file (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  // Write port from WB
  input  core_pkg::ex_wb_pipe_t           wb_pipe_i
);

  logic [core_pkg::XLEN-1:0] regs_q [core_pkg::NUM_REGS];
  logic                      wr_en;

  // Entry 0 never written
  assign wr_en = wb_pipe_i.valid && wb_pipe_i.rf_we && wb_pipe_i.rf_waddr != '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_pipe_i.rf_waddr] <= wb_pipe_i.rf_wdata;
    end
  end

  // Old value during the write cycle, ID covers it from WB
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

/* hdl/core_top.sv */
/*
 * Core top level
 * IF, ID and EX stages, register file, instruction and data OBI
 */
module core_top (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  input  logic                      fetch_enable_i,
  // Instruction OBI
  output logic                      instr_req_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic [core_pkg::XLEN-1:0] instr_rdata_i,
  // Data OBI, stores only
  output logic                      data_req_o,
  input  logic                      data_gnt_i,
  input  logic                      data_rvalid_i,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  output logic [obi_pkg::BE_W-1:0]  data_be_o
);
  import core_pkg::*;

  // Stage payloads
  if_id_pipe_t           if_id_pipe;
  id_ex_pipe_t           id_ex_pipe;
  ex_wb_pipe_t           ex_result;
  ex_wb_pipe_t           ex_wb_pipe;
  // Handshakes
  logic                  id_ready;
  logic                  ex_ready;
  // Register file read
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;

  //////////////////////////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////////////////////////

  if_stage if_stage_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .id_ready_i     (id_ready),
    .if_id_pipe_o   (if_id_pipe),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i)
  );

  //////////////////////////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////////////////////////

  id_stage id_stage_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .if_id_pipe_i (if_id_pipe),
    .ex_ready_i   (ex_ready),
    .id_ready_o   (id_ready),
    .id_ex_pipe_o (id_ex_pipe),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    // Forward from EX result and WB write
    .ex_result_i  (ex_result),
    .wb_pipe_i    (ex_wb_pipe)
  );

  //////////////////////////////////////////////////////////////////////
  // Execute and store
  //////////////////////////////////////////////////////////////////////

  ex_stage ex_stage_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .id_ex_pipe_i  (id_ex_pipe),
    .ex_ready_o    (ex_ready),
    .ex_result_o   (ex_result),
    .ex_wb_pipe_o  (ex_wb_pipe),
    .data_req_o    (data_req_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_be_o     (data_be_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i)
  );

  // WB is the register file write port
  register_file register_file_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wb_pipe_i (ex_wb_pipe)
  );

endmodule

/* bench/tb_mem_model.sv */
/*
 * Bus model for the core testbench
 * Instruction memory with NOP fill, store acceptance on the data bus
 * Random grant and response delays of up to 3 cycles
 */
module tb_mem_model (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] boot_addr_i,
  // Instruction OBI
  input  logic        instr_req_i,
  input  logic [31:0] instr_addr_i,
  output logic        instr_gnt_o,
  output logic        instr_rvalid_o,
  output logic [31:0] instr_rdata_o,
  // Data OBI
  input  logic        data_req_i,
  output logic        data_gnt_o,
  output logic        data_rvalid_o
);

  // Program words, filled by the testbench before reset ends
  logic [31:0] prog [64];
  int          prog_len;
  // Longest random wait in cycles, set by the testbench
  int          max_delay = 3;

  logic [1:0]  igcnt_q;
  logic [1:0]  ircnt_q;
  logic        ipend_q;
  logic [31:0] iaddr_q;
  logic [1:0]  dgcnt_q;
  logic [1:0]  drcnt_q;
  logic        dpend_q;

  // Grant once the random wait has run out
  assign instr_gnt_o = instr_req_i && igcnt_q == 2'd0;
  assign data_gnt_o  = data_req_i && dgcnt_q == 2'd0;

  // Word at a fetch address, NOP past the end of the program
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - boot_addr_i) >> 2;
    if (idx < 32'(prog_len)) begin
      return prog[idx[5:0]];
    end
    return 32'h0000_0013;
  endfunction

  // Wait of 0 to max_delay cycles
  function automatic logic [1:0] draw_delay();
    return 2'($urandom % 32'(max_delay + 1));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    logic [1:0] rdelay;
    if (!rst_n_i) begin
      igcnt_q        <= 2'd0;
      ircnt_q        <= 2'd0;
      ipend_q        <= 1'b0;
      instr_rvalid_o <= 1'b0;
      instr_rdata_o  <= 32'h0;
    end else begin
      instr_rvalid_o <= 1'b0;
      // Response after its delay
      if (ipend_q) begin
        if (ircnt_q == 2'd0) begin
          instr_rvalid_o <= 1'b1;
          instr_rdata_o  <= fetch_word(iaddr_q);
          ipend_q        <= 1'b0;
        end else begin
          ircnt_q <= ircnt_q - 2'd1;
        end
      end
      // New transfer wins over the finished one
      // Zero wait answers in the cycle right after the grant
      if (instr_gnt_o) begin
        rdelay  = draw_delay();
        igcnt_q <= draw_delay();
        if (rdelay == 2'd0) begin
          instr_rvalid_o <= 1'b1;
          instr_rdata_o  <= fetch_word(instr_addr_i);
        end else begin
          ipend_q <= 1'b1;
          iaddr_q <= instr_addr_i;
          ircnt_q <= rdelay - 2'd1;
        end
      end else if (instr_req_i) begin
        igcnt_q <= igcnt_q - 2'd1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data side, stores only
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    logic [1:0] rdelay;
    if (!rst_n_i) begin
      dgcnt_q       <= 2'd0;
      drcnt_q       <= 2'd0;
      dpend_q       <= 1'b0;
      data_rvalid_o <= 1'b0;
    end else begin
      data_rvalid_o <= 1'b0;
      if (dpend_q) begin
        if (drcnt_q == 2'd0) begin
          data_rvalid_o <= 1'b1;
          dpend_q       <= 1'b0;
        end else begin
          drcnt_q <= drcnt_q - 2'd1;
        end
      end
      if (data_gnt_o) begin
        rdelay  = draw_delay();
        dgcnt_q <= draw_delay();
        if (rdelay == 2'd0) begin
          data_rvalid_o <= 1'b1;
        end else begin
          dpend_q <= 1'b1;
          drcnt_q <= rdelay - 2'd1;
        end
      end else if (data_req_i) begin
        dgcnt_q <= dgcnt_q - 2'd1;
      end
    end
  end

endmodule

/* bench/tb_core.sv */
/*
 * Testbench for the core top level
 * Stimulus table, program builder, store capture, check task, report
 */
module tb_core;

  typedef enum logic [3:0] {
    T_ADD, T_SUB, T_AND, T_OR, T_XOR,
    T_ADDI, T_ANDI, T_ORI, T_XORI, T_LUI, T_X0
  } tb_op_e;

  // One table row, b is rs2 value or the immediate
  typedef struct packed {
    tb_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] addr;
    logic [31:0] exp;
  } row_t;

  localparam int NUM_ROWS = 11;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] boot_addr;
  logic        fetch_enable;
  logic        instr_req;
  logic        instr_gnt;
  logic        instr_rvalid;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic        data_req;
  logic        data_gnt;
  logic        data_rvalid;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [3:0]  data_be;

  row_t        rows [NUM_ROWS];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  logic [3:0]  st_be_q [$];
  int          err_count;
  int          test_count;

  core_top UUT (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_be_o      (data_be)
  );

  tb_mem_model mem_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .boot_addr_i    (boot_addr),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_gnt_o    (instr_gnt),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .data_req_i     (data_req),
    .data_gnt_o     (data_gnt),
    .data_rvalid_o  (data_rvalid)
  );

  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  // Store capture in the stable low phase
  always @(negedge clk_i) begin
    if (rst_n_i && data_req && data_gnt) begin
      st_addr_q.push_back(data_addr);
      st_data_q.push_back(data_wdata);
      st_be_q.push_back(data_be);
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference results and instruction encoders
  //////////////////////////////////////////////////////////////////////

  // RV32I result rule per operation
  function automatic logic [31:0] expect_result(input tb_op_e op, input logic [31:0] a,
                                                input logic [31:0] b);
    case (op)
      T_ADD, T_ADDI: return a + b;
      T_SUB:         return a - b;
      T_AND, T_ANDI: return a & b;
      T_OR, T_ORI:   return a | b;
      T_XOR, T_XORI: return a ^ b;
      T_LUI:         return {b[19:0], 12'h000};
      default:       return 32'h0;
    endcase
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
    // rd x3, rs1 x1, rs2 x2
    return {f7, 5'd2, 5'd1, f3, 5'd3, 7'h33};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  // SW rs2 to imm(x0)
  function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  // LUI plus ADDI, upper part rounded for the signed low part
  task automatic load_const(input logic [4:0] rd, input logic [31:0] val, inout int idx);
    logic [31:0] hi;
    hi = (val + 32'h800) >> 12;
    mem_i.prog[idx] = enc_lui(hi[19:0], rd);
    mem_i.prog[idx + 1] = enc_i(val[11:0], rd, 3'b000, rd);
    idx += 2;
  endtask

  // Operands, operation, result store, then a store of operand A
  task automatic build_program(input row_t r);
    int          idx;
    logic [4:0]  res_reg;
    logic [31:0] op_word;
    idx = 0;
    res_reg = 5'd3;
    load_const(5'd1, r.a, idx);
    load_const(5'd2, r.b, idx);
    case (r.op)
      T_ADD:   op_word = enc_r(7'h00, 3'b000);
      T_SUB:   op_word = enc_r(7'h20, 3'b000);
      T_AND:   op_word = enc_r(7'h00, 3'b111);
      T_OR:    op_word = enc_r(7'h00, 3'b110);
      T_XOR:   op_word = enc_r(7'h00, 3'b100);
      T_ADDI:  op_word = enc_i(r.b[11:0], 5'd1, 3'b000, 5'd3);
      T_ANDI:  op_word = enc_i(r.b[11:0], 5'd1, 3'b111, 5'd3);
      T_ORI:   op_word = enc_i(r.b[11:0], 5'd1, 3'b110, 5'd3);
      T_XORI:  op_word = enc_i(r.b[11:0], 5'd1, 3'b100, 5'd3);
      T_LUI:   op_word = enc_lui(r.b[19:0], 5'd3);
      default: begin
        // Write to x0, then store x0
        op_word = enc_i(r.b[11:0], 5'd1, 3'b000, 5'd0);
        res_reg = 5'd0;
      end
    endcase
    mem_i.prog[idx] = op_word;
    mem_i.prog[idx + 1] = enc_sw(r.addr, res_reg);
    mem_i.prog[idx + 2] = enc_sw(r.addr + 12'd4, 5'd1);
    mem_i.prog_len = idx + 3;
  endtask

  task automatic reset_core();
    rst_n_i = 1'b0;
    fetch_enable = 1'b0;
    repeat (4) @(negedge clk_i);
    st_addr_q.delete();
    st_data_q.delete();
    st_be_q.delete();
    rst_n_i = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          errs_before;
    int          req_count;
    int          cycles;
    int          ri;
    bit          ok;
    tb_op_e      op;
    logic [31:0] sext_imm;
    rst_n_i = 1'b0;
    fetch_enable = 1'b0;
    boot_addr = 32'h0000_1000;
    err_count = 0;
    test_count = 0;
    void'($urandom(91270));
    // Table, random operands on most rows
    for (int i = 0; i < NUM_ROWS; i++) begin
      op = tb_op_e'(i);
      sext_imm = {{20{1'b0}}, 12'($urandom)};
      sext_imm = {{20{sext_imm[11]}}, sext_imm[11:0]};
      rows[i].op = op;
      rows[i].a = $urandom;
      rows[i].b = (i < 5) ? $urandom : sext_imm;
      if (op == T_LUI) rows[i].b = {12'h0, 20'($urandom)};
      rows[i].addr = 12'h100 + 12'(8 * i);
      rows[i].exp = expect_result(op, rows[i].a, rows[i].b);
    end
    // Fixed corner for SUB
    rows[1].a = 32'h0000_0000;
    rows[1].b = 32'h0000_0001;
    rows[1].exp = expect_result(T_SUB, rows[1].a, rows[1].b);

    // First pass with no bus waits, so a producer sits in WB
    // while its consumer decodes; second pass with random waits
    for (int t = 0; t < 2 * NUM_ROWS; t++) begin
      errs_before = err_count;
      ok = 1'b1;
      ri = t % NUM_ROWS;
      op = rows[ri].op;
      mem_i.max_delay = (t < NUM_ROWS) ? 0 : 3;
      boot_addr = 32'h0000_1000 + 32'(t * 256);
      build_program(rows[ri]);
      reset_core();
      // Fetch disabled window, no bus activity
      req_count = 0;
      for (int c = 0; c < 20; c++) begin
        @(negedge clk_i);
        if (instr_req || data_req) req_count++;
      end
      check_value("instr_req_o/data_req_o count", 32'(req_count), 32'h0);
      fetch_enable = 1'b1;
      #1;
      cycles = 0;
      while (!instr_req && cycles < 20) begin
        @(negedge clk_i);
        #1;
        cycles++;
      end
      if (!instr_req) begin
        $display("Timeout in test %0d: no instruction request after fetch enable", t);
        err_count++;
        ok = 1'b0;
      end else begin
        check_value("instr_addr_o", instr_addr, boot_addr);
      end
      // Both stores of the program
      cycles = 0;
      while (ok && st_addr_q.size() < 2 && cycles < 400) begin
        @(negedge clk_i);
        #1;
        cycles++;
      end
      if (ok && st_addr_q.size() < 2) begin
        $display("Timeout in test %0d: stores did not arrive", t);
        err_count++;
        ok = 1'b0;
      end
      if (ok) begin
        // Trailing NOPs must add no store
        repeat (40) @(negedge clk_i);
        check_value("store count", 32'(st_addr_q.size()), 32'd2);
        check_value("data_addr_o", st_addr_q[0], {20'h0, rows[ri].addr});
        check_value("data_wdata_o", st_data_q[0], rows[ri].exp);
        check_value("data_be_o", {28'h0, st_be_q[0]}, 32'hf);
        check_value("data_addr_o", st_addr_q[1], {20'h0, rows[ri].addr + 12'd4});
        check_value("data_wdata_o", st_data_q[1], rows[ri].a);
        check_value("data_be_o", {28'h0, st_be_q[1]}, 32'hf);
      end
      test_count++;
      $display("Test %0d %s max wait %0d: %s", t, op.name(), mem_i.max_delay,
               (err_count == errs_before) ? "pass" : "FAIL");
    end

    $display("Tests run %0d, errors %0d", test_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/core_pkg.sv
hdl/obi_pkg.sv
hdl/obi_port.sv
hdl/if_stage.sv
hdl/id_stage.sv
hdl/ex_stage.sv
hdl/register_file.sv
hdl/core_top.sv
bench/tb_mem_model.sv
bench/tb_core.sv

/* Makefile */
# Verilator flow for the core testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_core
RTL_TOP   ?= core_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi
	@grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
